/* common/ti99_macros.svh */
// Memory map, packaged-cartridge header layout and PS/2 scancode constants
`ifndef TI99_MACROS_SVH
`define TI99_MACROS_SVH

// ===========================================================================
// External memory regions (byte addresses)
// ===========================================================================
`define TI_ROM_HI_LIMIT   'h80000   // Cart ROM above 512K moves past SAMS RAM
`define TI_ROM_HI_OFFSET  'h180000
`define TI_GROM_BASE      'h86000
`define TI_SYSGROM_BASE   'h80000
`define TI_SYSROM_BASE    'hFE000
`define TI_DSK_BASE       'hB0000
`define TI_TIPI_BASE      'hB8000
`define TI_PCODE_BASE     'hB9000

// Bytes each index may write
`define TI_GROM_LIMIT     'h2A000   // 168K of cart GROM
`define TI_SYSGROM_LIMIT  'h6000
`define TI_SYSROM_LIMIT   'h2000
`define TI_DSK_LIMIT      'h8000
`define TI_TIPI_LIMIT     'h1000    // Only 4K of the DSR image is live
`define TI_PCODE_LIMIT    'h13000

// ===========================================================================
// Packaged cartridge header
// ===========================================================================
`define TI_M99_HDR_LEN       'h64
`define TI_M99_SIG           'h4D3939   // "M99"
`define TI_BANK_BYTES        'h2000     // 8K per bank
`define TI_M99_OFS_SIG_LAST  2
`define TI_M99_OFS_TYPE      4
`define TI_M99_OFS_ROMB      5          // High byte, low byte follows
`define TI_M99_OFS_GROMB     7

// Key matrix row shared with the alpha-lock line
`define TI_ALPHA_ROW         4

// ===========================================================================
// PS/2 set 2 scancodes
// ===========================================================================
`define TI_SC_1        8'h16
`define TI_SC_2        8'h1E
`define TI_SC_3        8'h26
`define TI_SC_4        8'h25
`define TI_SC_5        8'h2E
`define TI_SC_6        8'h36
`define TI_SC_7        8'h3D
`define TI_SC_8        8'h3E
`define TI_SC_9        8'h46
`define TI_SC_0        8'h45
`define TI_SC_MINUS    8'h4E
`define TI_SC_EQUAL    8'h55
`define TI_SC_BSLASH   8'h5D
`define TI_SC_Q        8'h15
`define TI_SC_W        8'h1D
`define TI_SC_E        8'h24
`define TI_SC_R        8'h2D
`define TI_SC_T        8'h2C
`define TI_SC_Y        8'h35
`define TI_SC_U        8'h3C
`define TI_SC_I        8'h43
`define TI_SC_O        8'h44
`define TI_SC_P        8'h4D
`define TI_SC_LBRACK   8'h54
`define TI_SC_A        8'h1C
`define TI_SC_S        8'h1B
`define TI_SC_D        8'h23
`define TI_SC_F        8'h2B
`define TI_SC_G        8'h34
`define TI_SC_H        8'h33
`define TI_SC_J        8'h3B
`define TI_SC_K        8'h42
`define TI_SC_L        8'h4B
`define TI_SC_SEMI     8'h4C
`define TI_SC_ENTER    8'h5A
`define TI_SC_LSHIFT   8'h12
`define TI_SC_Z        8'h1A
`define TI_SC_X        8'h22
`define TI_SC_C        8'h21
`define TI_SC_V        8'h2A
`define TI_SC_B        8'h32
`define TI_SC_N        8'h31
`define TI_SC_M        8'h3A
`define TI_SC_COMMA    8'h41
`define TI_SC_PERIOD   8'h49
`define TI_SC_SLASH    8'h4A
`define TI_SC_RSHIFT   8'h59
`define TI_SC_CAPS     8'h58
`define TI_SC_LCTRL    8'h14
`define TI_SC_SPACE    8'h29
`define TI_SC_LALT     8'h11
`define TI_SC_QUOTE    8'h52
`define TI_SC_BKSP     8'h66
`define TI_SC_DEL      8'h71
`define TI_SC_INS      8'h70
`define TI_SC_ESC      8'h76
`define TI_SC_LEFT     8'h6B
`define TI_SC_DOWN     8'h72
`define TI_SC_RIGHT    8'h74
`define TI_SC_UP       8'h75
`define TI_SC_BTICK    8'h0E

`endif

/* common/ti99_pkg.sv */
// Shared types for the cartridge loader and keyboard paths
package ti99_pkg;

	// ========================================================================
	// Loader types
	// ========================================================================
	typedef enum logic [7:0] {
		IDX_BOOT    = 8'd0,  // Packaged cart
		IDX_M99     = 8'd1,  // Packaged cart, second menu slot
		IDX_ROM     = 8'd2,  // ROM-only cart
		IDX_GROM    = 8'd3,
		IDX_SYSGROM = 8'd4,
		IDX_SYSROM  = 8'd5,
		IDX_SPEECH  = 8'd6,  // Goes to speech RAM, never external memory
		IDX_DSK     = 8'd7,
		IDX_TIPI    = 8'd8,
		IDX_PCODE   = 8'd9
	} load_idx_e;

	// One download byte and where it sits in the file
	typedef struct packed {
		logic        download;
		logic        wr;
		load_idx_e   index;
		logic [26:0] addr;
		logic [7:0]  data;
	} ioctl_t;

	// Write toward external memory
	typedef struct packed {
		logic        wr;
		logic [25:0] addr;  // Bit 0 already flipped for word byte order
		logic [15:0] data;  // Byte on both lanes
	} mem_wr_t;

	// Decoded packaged-cart header
	typedef struct packed {
		logic        valid;
		logic [2:0]  cart_type;
		logic [15:0] rom_banks;
		logic [15:0] grom_banks;
	} cart_info_t;

	// ========================================================================
	// Keyboard types
	// ========================================================================
	typedef struct packed {
		logic       toggle;    // Flips on every event
		logic       pressed;
		logic       extended;  // E0 prefix
		logic [7:0] code;
	} ps2_key_t;

	// Held keys, col[c][r] is column c row r, 1 = down
	typedef struct packed {
		logic [7:0][7:0] col;
	} key_mat_t;

	// Console select lines, active low
	typedef struct packed {
		logic       alpha_n;  // Bit 8
		logic [7:0] col_n;
	} key_sel_t;

endpackage

/* loader/m99_header.sv */
// Packaged-cartridge header parser holding the cartridge description
`include "ti99_macros.svh"

module m99_header (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  ti99_pkg::ioctl_t      ioctl_i,
	output ti99_pkg::cart_info_t  cart_o
);

	import ti99_pkg::*;

	cart_info_t  cart_q;
	logic [23:0] sig_q;     // Signature bytes, first byte ends up on top
	logic [23:0] sig_next;
	logic        hdr_wr;

	// Header bytes only arrive on the two packaged-cart indexes
	assign hdr_wr = ioctl_i.download & ioctl_i.wr &
		((ioctl_i.index == IDX_BOOT) | (ioctl_i.index == IDX_M99));

	assign sig_next = {sig_q[15:0], ioctl_i.data};

	// Signature shift register
	always_ff @(posedge clk_sys) begin
		if (hdr_wr && (ioctl_i.addr <= `TI_M99_OFS_SIG_LAST)) begin
			sig_q <= sig_next;
		end
	end

	// ========================================================================
	// Validity and fields
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q <= '0;
		end else if (hdr_wr) begin
			case (ioctl_i.addr)
				0, 1: cart_q.valid <= 1'b0; // New file or signature rewrite
				`TI_M99_OFS_SIG_LAST: cart_q.valid <= (sig_next == `TI_M99_SIG);
				`TI_M99_OFS_TYPE: begin
					if (cart_q.valid) cart_q.cart_type <= ioctl_i.data[2:0];
				end
				`TI_M99_OFS_ROMB: begin
					if (cart_q.valid) cart_q.rom_banks[15:8] <= ioctl_i.data;
				end
				`TI_M99_OFS_ROMB + 1: begin
					if (cart_q.valid) cart_q.rom_banks[7:0] <= ioctl_i.data;
				end
				`TI_M99_OFS_GROMB: begin
					if (cart_q.valid) cart_q.grom_banks[15:8] <= ioctl_i.data;
				end
				`TI_M99_OFS_GROMB + 1: begin
					if (cart_q.valid) cart_q.grom_banks[7:0] <= ioctl_i.data;
				end
				default: ; // Version, title, maker, serial
			endcase
		end
	end

	assign cart_o = cart_q;

	// Description only stays valid behind a good signature
	a_valid_sig: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_q.valid |-> (sig_q == `TI_M99_SIG));

endmodule

/* loader/cart_loader.sv */
// Download byte to external-memory address and write strobe mapping
`include "ti99_macros.svh"

module cart_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  ti99_pkg::ioctl_t      ioctl_i,
	input  ti99_pkg::cart_info_t  cart_i,
	output ti99_pkg::mem_wr_t     mem_o
);

	import ti99_pkg::*;

	mem_wr_t     mem_q;
	logic [31:0] a32;       // Download address, widened
	logic [31:0] off;       // Payload offset past the header
	logic [31:0] rom_end;
	logic [31:0] grom_end;
	logic [31:0] byte_a;    // Target byte address
	logic        hit;       // Byte goes to memory

	// Cart ROM above 512K skips over the SAMS area
	function automatic logic [31:0] rom_reloc(input logic [31:0] a);
		if (a >= `TI_ROM_HI_LIMIT) begin
			return a + `TI_ROM_HI_OFFSET;
		end
		return a;
	endfunction

	assign a32      = 32'(ioctl_i.addr);
	assign off      = a32 - `TI_M99_HDR_LEN;
	assign rom_end  = 32'(cart_i.rom_banks) * `TI_BANK_BYTES;
	assign grom_end = rom_end + 32'(cart_i.grom_banks) * `TI_BANK_BYTES;

	// ========================================================================
	// Address map per index
	// ========================================================================
	always_comb begin
		byte_a = a32;
		hit    = 1'b0;
		case (ioctl_i.index)
			IDX_BOOT, IDX_M99: begin
				if (!cart_i.valid || (a32 < `TI_M99_HDR_LEN)) begin
					hit = 1'b0;                       // Header or bad file
				end else if (off < rom_end) begin
					byte_a = rom_reloc(off);
					hit    = 1'b1;
				end else if (off < grom_end) begin
					byte_a = off - rom_end + `TI_GROM_BASE;
					hit    = 1'b1;
				end
			end
			IDX_ROM: begin
				byte_a = rom_reloc(a32);              // No size limit
				hit    = 1'b1;
			end
			IDX_GROM: begin
				byte_a = a32 + `TI_GROM_BASE;
				hit    = (a32 < `TI_GROM_LIMIT);
			end
			IDX_SYSGROM: begin
				byte_a = a32 + `TI_SYSGROM_BASE;
				hit    = (a32 < `TI_SYSGROM_LIMIT);
			end
			IDX_SYSROM: begin
				byte_a = a32 + `TI_SYSROM_BASE;
				hit    = (a32 < `TI_SYSROM_LIMIT);
			end
			IDX_SPEECH: hit = 1'b0;                   // Speech RAM only
			IDX_DSK: begin
				byte_a = a32 + `TI_DSK_BASE;
				hit    = (a32 < `TI_DSK_LIMIT);
			end
			IDX_TIPI: begin
				byte_a = a32 + `TI_TIPI_BASE;
				hit    = (a32 < `TI_TIPI_LIMIT);
			end
			IDX_PCODE: begin
				byte_a = a32 + `TI_PCODE_BASE;
				hit    = (a32 < `TI_PCODE_LIMIT);
			end
			default: hit = 1'b0;                      // Unknown index dropped
		endcase
	end

	// Output register, one cycle behind the download byte
	always_ff @(posedge clk_sys) begin
		mem_q.addr <= {byte_a[25:1], ~byte_a[0]};  // Big-endian word swap
		mem_q.data <= {2{ioctl_i.data}};
		if (RESET) begin
			mem_q.wr <= 1'b0;
		end else begin
			mem_q.wr <= ioctl_i.download & ioctl_i.wr & hit;
		end
	end

	assign mem_o = mem_q;

	a_no_speech_wr: assert property (@(posedge clk_sys) disable iff (RESET)
		(ioctl_i.wr && (ioctl_i.index == IDX_SPEECH)) |=> !mem_o.wr);

endmodule

/* keyboard/ps2_key_decode.sv */
// PS/2 scancode events to held-key matrix, function combinations and alpha lock
`include "ti99_macros.svh"

module ps2_key_decode (
	input  logic                clk_sys,
	input  logic                RESET,
	input  ti99_pkg::ps2_key_t  key_i,
	input  logic                virt_joy_i,
	output ti99_pkg::key_mat_t  mat_o,
	output logic                alpha_lock_o
);

	import ti99_pkg::*;

	key_mat_t mat_q;
	logic     alpha_q;
	logic     toggle_q;
	logic     pressed;

	assign pressed = key_i.pressed;

	// Last toggle seen, events are its edges
	always_ff @(posedge clk_sys) begin
		toggle_q <= key_i.toggle;
	end

	// ========================================================================
	// Scancode to matrix, col[c][r]
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mat_q   <= '0;
			alpha_q <= 1'b0;
		end else if (toggle_q != key_i.toggle) begin
			// E0 prefix ignored, arrows share codes with the keypad
			case (key_i.code)
				`TI_SC_BTICK:  mat_q.col[1][0] <= pressed; // Joystick 1 fire
				`TI_SC_1:      mat_q.col[2][4] <= pressed;
				`TI_SC_2:      mat_q.col[6][4] <= pressed;
				`TI_SC_3:      mat_q.col[5][4] <= pressed;
				`TI_SC_4:      mat_q.col[4][4] <= pressed;
				`TI_SC_5:      mat_q.col[3][4] <= pressed;
				`TI_SC_6:      mat_q.col[3][3] <= pressed;
				`TI_SC_7:      mat_q.col[4][3] <= pressed;
				`TI_SC_8:      mat_q.col[5][3] <= pressed;
				`TI_SC_9:      mat_q.col[6][3] <= pressed;
				`TI_SC_0:      mat_q.col[2][3] <= pressed;
				`TI_SC_MINUS,
				`TI_SC_EQUAL,
				`TI_SC_BSLASH: mat_q.col[7][0] <= pressed; // All land on =
				`TI_SC_Q:      mat_q.col[2][6] <= pressed;
				`TI_SC_W:      mat_q.col[6][6] <= pressed;
				`TI_SC_E:      mat_q.col[5][6] <= pressed;
				`TI_SC_R:      mat_q.col[4][6] <= pressed;
				`TI_SC_T:      mat_q.col[3][6] <= pressed;
				`TI_SC_Y:      mat_q.col[3][2] <= pressed;
				`TI_SC_U:      mat_q.col[4][2] <= pressed;
				`TI_SC_I:      mat_q.col[5][2] <= pressed;
				`TI_SC_O:      mat_q.col[6][2] <= pressed;
				`TI_SC_P:      mat_q.col[2][2] <= pressed;
				`TI_SC_LBRACK,
				`TI_SC_SLASH:  mat_q.col[2][0] <= pressed; // Both give /
				`TI_SC_A:      mat_q.col[2][5] <= pressed;
				`TI_SC_S:      mat_q.col[6][5] <= pressed;
				`TI_SC_D:      mat_q.col[5][5] <= pressed;
				`TI_SC_F:      mat_q.col[4][5] <= pressed;
				`TI_SC_G:      mat_q.col[3][5] <= pressed;
				`TI_SC_H:      mat_q.col[3][1] <= pressed;
				`TI_SC_J:      mat_q.col[4][1] <= pressed;
				`TI_SC_K:      mat_q.col[5][1] <= pressed;
				`TI_SC_L:      mat_q.col[6][1] <= pressed;
				`TI_SC_SEMI:   mat_q.col[2][1] <= pressed;
				`TI_SC_ENTER:  mat_q.col[7][2] <= pressed;
				`TI_SC_LSHIFT,
				`TI_SC_RSHIFT: mat_q.col[7][5] <= pressed;
				`TI_SC_Z:      mat_q.col[2][7] <= pressed;
				`TI_SC_X:      mat_q.col[6][7] <= pressed;
				`TI_SC_C:      mat_q.col[5][7] <= pressed;
				`TI_SC_V:      mat_q.col[4][7] <= pressed;
				`TI_SC_B:      mat_q.col[3][7] <= pressed;
				`TI_SC_N:      mat_q.col[3][0] <= pressed;
				`TI_SC_M:      mat_q.col[4][0] <= pressed;
				`TI_SC_COMMA:  mat_q.col[5][0] <= pressed;
				`TI_SC_PERIOD: mat_q.col[6][0] <= pressed;
				`TI_SC_LCTRL:  mat_q.col[7][6] <= pressed;
				`TI_SC_SPACE:  mat_q.col[7][1] <= pressed;
				`TI_SC_LALT:   mat_q.col[7][4] <= pressed; // FCTN
				`TI_SC_CAPS:   alpha_q <= alpha_q ^ pressed; // Flip on make only

				// FCTN combinations
				`TI_SC_QUOTE: begin
					mat_q.col[7][4] <= pressed;
					mat_q.col[2][2] <= pressed; // FCTN-P
				end
				`TI_SC_BKSP: begin
					mat_q.col[7][4] <= pressed;
					mat_q.col[6][5] <= pressed; // FCTN-S
				end
				`TI_SC_DEL: begin
					mat_q.col[7][4] <= pressed;
					mat_q.col[2][4] <= pressed; // FCTN-1
				end
				`TI_SC_INS: begin
					mat_q.col[7][4] <= pressed;
					mat_q.col[6][4] <= pressed; // FCTN-2
				end
				`TI_SC_ESC: begin
					mat_q.col[7][4] <= pressed;
					mat_q.col[6][3] <= pressed; // FCTN-9, back
				end

				// Arrows, joystick 1 sits in column 1
				`TI_SC_UP: begin
					if (virt_joy_i) begin
						mat_q.col[1][4] <= pressed;
					end else begin
						mat_q.col[7][4] <= pressed;
						mat_q.col[5][6] <= pressed; // FCTN-E
					end
				end
				`TI_SC_DOWN: begin
					if (virt_joy_i) begin
						mat_q.col[1][3] <= pressed;
					end else begin
						mat_q.col[7][4] <= pressed;
						mat_q.col[6][7] <= pressed; // FCTN-X
					end
				end
				`TI_SC_LEFT: begin
					if (virt_joy_i) begin
						mat_q.col[1][1] <= pressed;
					end else begin
						mat_q.col[7][4] <= pressed;
						mat_q.col[6][5] <= pressed; // FCTN-S
					end
				end
				`TI_SC_RIGHT: begin
					if (virt_joy_i) begin
						mat_q.col[1][2] <= pressed;
					end else begin
						mat_q.col[7][4] <= pressed;
						mat_q.col[5][5] <= pressed; // FCTN-D
					end
				end
				default: ;
			endcase
		end
	end

	assign mat_o        = mat_q;
	assign alpha_lock_o = alpha_q;

	a_key_known: assert property (@(posedge clk_sys) disable iff (RESET)
		!$isunknown(key_i));

endmodule

/* keyboard/key_matrix_scan.sv */
// Column select to active-low row data, with the alpha-lock line
`include "ti99_macros.svh"

module key_matrix_scan (
	input  logic                clk_sys,
	input  logic                RESET,
	input  ti99_pkg::key_mat_t  mat_i,
	input  logic                alpha_lock_i,
	input  ti99_pkg::key_sel_t  sel_i,
	output logic [7:0]          keys_o
);

	logic [7:0] rows_n;   // Next row data, 0 = key down
	logic [7:0] keys_q;

	// ========================================================================
	// Row decode
	// ========================================================================
	always_comb begin
		rows_n = '1;
		for (int c = 0; c < 8; c++) begin
			if (!sel_i.col_n[c]) begin
				rows_n = rows_n & ~mat_i.col[c];    // Any held key pulls its row
			end
		end
		// Alpha lock has its own select, shares row 4
		if (alpha_lock_i && !sel_i.alpha_n) begin
			rows_n[`TI_ALPHA_ROW] = 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			keys_q <= '1;   // Nothing pressed
		end else begin
			keys_q <= rows_n;
		end
	end

	assign keys_o = keys_q;

endmodule

/* rtl/ti99_io_top.sv */
// Top level joining the cartridge loader and keyboard paths
module ti99_io_top (
	input  logic                  clk_sys,
	input  logic                  RESET,
	// Download side
	input  ti99_pkg::ioctl_t      ioctl_i,
	output ti99_pkg::mem_wr_t     mem_o,
	output ti99_pkg::cart_info_t  cart_o,
	// Keyboard side
	input  ti99_pkg::ps2_key_t    ps2_key_i,
	input  logic                  virt_joy_i,    // Arrows drive joystick 1
	input  ti99_pkg::key_sel_t    key_sel_i,
	output logic [7:0]            keys_o
);

	import ti99_pkg::*;

	key_mat_t key_mat;
	logic     alpha_lock;

	// ========================================================================
	// Loader
	// ========================================================================
	m99_header i_m99_header (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ioctl_i (ioctl_i),
		.cart_o  (cart_o)
	);

	cart_loader i_cart_loader (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ioctl_i (ioctl_i),
		.cart_i  (cart_o),      // Header result steers the payload
		.mem_o   (mem_o)
	);

	// ========================================================================
	// Keyboard
	// ========================================================================
	ps2_key_decode i_ps2_key_decode (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.key_i        (ps2_key_i),
		.virt_joy_i   (virt_joy_i),
		.mat_o        (key_mat),
		.alpha_lock_o (alpha_lock)
	);

	key_matrix_scan i_key_matrix_scan (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.mat_i        (key_mat),
		.alpha_lock_i (alpha_lock),
		.sel_i        (key_sel_i),
		.keys_o       (keys_o)
	);

endmodule

/* verif/tb_ti99_ref.svh */
// Reference model functions for the memory map, header fields and key matrix rows
`ifndef TB_TI99_REF_SVH
`define TB_TI99_REF_SVH

`include "ti99_macros.svh"

// ===========================================================================
// Loader reference
// ===========================================================================
function automatic logic [31:0] ref_reloc(input logic [31:0] a);
	return (a >= `TI_ROM_HI_LIMIT) ? a + `TI_ROM_HI_OFFSET : a;   // Skip SAMS area
endfunction

function automatic mem_wr_t ref_mem(input ioctl_t io, input cart_info_t c);
	logic [31:0] a;
	logic [31:0] off;
	logic [31:0] rom_sz;
	logic [31:0] grom_sz;
	logic [31:0] base;
	logic [31:0] lim;     // 0 for indexes without a fixed region
	logic [31:0] t;
	logic        hit;
	mem_wr_t     m;
	a       = 32'(io.addr);
	off     = a - `TI_M99_HDR_LEN;
	rom_sz  = 32'(c.rom_banks) * `TI_BANK_BYTES;
	grom_sz = 32'(c.grom_banks) * `TI_BANK_BYTES;
	base    = '0;
	lim     = '0;
	t       = a;
	hit     = 1'b0;
	case (io.index)
		IDX_BOOT, IDX_M99: begin
			if (c.valid && (a >= `TI_M99_HDR_LEN)) begin
				if (off < rom_sz) begin
					t   = ref_reloc(off);
					hit = 1'b1;
				end else if (off - rom_sz < grom_sz) begin
					t   = off - rom_sz + `TI_GROM_BASE;   // GROM right after ROM banks
					hit = 1'b1;
				end
			end
		end
		IDX_ROM: begin
			t   = ref_reloc(a);
			hit = 1'b1;
		end
		IDX_GROM:    begin base = `TI_GROM_BASE;    lim = `TI_GROM_LIMIT;    end
		IDX_SYSGROM: begin base = `TI_SYSGROM_BASE; lim = `TI_SYSGROM_LIMIT; end
		IDX_SYSROM:  begin base = `TI_SYSROM_BASE;  lim = `TI_SYSROM_LIMIT;  end
		IDX_DSK:     begin base = `TI_DSK_BASE;     lim = `TI_DSK_LIMIT;     end
		IDX_TIPI:    begin base = `TI_TIPI_BASE;    lim = `TI_TIPI_LIMIT;    end
		IDX_PCODE:   begin base = `TI_PCODE_BASE;   lim = `TI_PCODE_LIMIT;   end
		default: ;   // Speech and unknown never reach memory
	endcase
	if (lim != 0) begin
		t   = a + base;
		hit = (a < lim);
	end
	m.wr   = io.download & io.wr & hit;
	m.addr = {t[25:1], ~t[0]};   // Word byte swap
	m.data = {2{io.data}};
	return m;
endfunction

// Header bytes only under the packaged-cart indexes
function automatic logic hdr_write(input ioctl_t io);
	return io.download && io.wr && ((io.index == IDX_BOOT) || (io.index == IDX_M99));
endfunction

function automatic logic [23:0] ref_sig_next(input logic [23:0] sig, input ioctl_t io);
	if (hdr_write(io) && (io.addr <= 2)) begin
		return {sig[15:0], io.data};
	end
	return sig;
endfunction

function automatic cart_info_t ref_cart_next(input cart_info_t c, input logic [23:0] sig,
		input ioctl_t io);
	cart_info_t n;
	n = c;
	if (hdr_write(io)) begin
		if (io.addr == 0) begin
			n.valid = 1'b0;                        // Start of a new file
		end else if (io.addr == 2) begin
			n.valid = (sig == `TI_M99_SIG);
		end else if (c.valid) begin
			case (io.addr)
				4: n.cart_type        = io.data[2:0];
				5: n.rom_banks[15:8]  = io.data;   // High byte first
				6: n.rom_banks[7:0]   = io.data;
				7: n.grom_banks[15:8] = io.data;
				8: n.grom_banks[7:0]  = io.data;
				default: ;
			endcase
		end
	end
	return n;
endfunction

// ===========================================================================
// Keyboard reference
// ===========================================================================
function automatic logic [63:0] key_bit(input int c, input int r);
	return 64'h1 << (c * 8 + r);   // Same bit order as key_mat_t
endfunction

function automatic logic [63:0] ref_key_mask(input logic [7:0] code, input logic vj);
	logic [63:0] fctn;
	fctn = key_bit(7, 4);
	case (code)
		`TI_SC_1:      return key_bit(2, 4);
		`TI_SC_2:      return key_bit(6, 4);
		`TI_SC_9:      return key_bit(6, 3);
		`TI_SC_Q:      return key_bit(2, 6);
		`TI_SC_E:      return key_bit(5, 6);
		`TI_SC_P:      return key_bit(2, 2);
		`TI_SC_A:      return key_bit(2, 5);
		`TI_SC_S:      return key_bit(6, 5);
		`TI_SC_D:      return key_bit(5, 5);
		`TI_SC_Z:      return key_bit(2, 7);
		`TI_SC_X:      return key_bit(6, 7);
		`TI_SC_M:      return key_bit(4, 0);
		`TI_SC_ENTER:  return key_bit(7, 2);
		`TI_SC_SPACE:  return key_bit(7, 1);
		`TI_SC_LSHIFT: return key_bit(7, 5);
		`TI_SC_LCTRL:  return key_bit(7, 6);
		`TI_SC_LALT:   return fctn;
		`TI_SC_BTICK:  return key_bit(1, 0);         // Joystick fire
		`TI_SC_QUOTE:  return fctn | key_bit(2, 2);
		`TI_SC_BKSP:   return fctn | key_bit(6, 5);
		`TI_SC_DEL:    return fctn | key_bit(2, 4);
		`TI_SC_INS:    return fctn | key_bit(6, 4);
		`TI_SC_ESC:    return fctn | key_bit(6, 3);
		`TI_SC_UP:     return vj ? key_bit(1, 4) : fctn | key_bit(5, 6);
		`TI_SC_DOWN:   return vj ? key_bit(1, 3) : fctn | key_bit(6, 7);
		`TI_SC_LEFT:   return vj ? key_bit(1, 1) : fctn | key_bit(6, 5);
		`TI_SC_RIGHT:  return vj ? key_bit(1, 2) : fctn | key_bit(5, 5);
		default:       return '0;
	endcase
endfunction

// Active-low rows seen by the console for a select pattern
function automatic logic [7:0] ref_rows(input key_mat_t m, input logic alpha,
		input key_sel_t s);
	logic [7:0] r;
	r = 8'hFF;
	for (int c = 0; c < 8; c++) begin
		for (int k = 0; k < 8; k++) begin
			if (!s.col_n[c] && m.col[c][k]) r[k] = 1'b0;
		end
	end
	if (alpha && !s.alpha_n) r[`TI_ALPHA_ROW] = 1'b0;
	return r;
endfunction

`endif

/* verif/tb_ti99_io.sv */
// Testbench for the loader and keyboard top level, with cycle model compare
module tb_ti99_io;
	timeunit 1ns;
	timeprecision 1ps;

	import ti99_pkg::*;
	`include "tb_ti99_ref.svh"

	localparam int N_MAP  = 40;    // Random bytes per fixed index
	localparam int N_PAY  = 150;   // Payload bytes per packaged cart
	localparam int N_KEYS = 60;
	// Cycles of each test part, doubled below for margin
	localparam int RUN_CYCLES = 5 + 8 * N_MAP + 2 * (`TI_M99_HDR_LEN + N_PAY)
		+ 6 * N_KEYS + 2 * 9 * 20 + 4 * 20 + 20;
	localparam int MAX_CYCLES = 2 * RUN_CYCLES + 100;

	localparam logic [17:0][7:0] PLAIN_KEYS = {`TI_SC_1, `TI_SC_2, `TI_SC_9, `TI_SC_Q,
		`TI_SC_E, `TI_SC_P, `TI_SC_A, `TI_SC_S, `TI_SC_D, `TI_SC_Z, `TI_SC_X, `TI_SC_M,
		`TI_SC_ENTER, `TI_SC_SPACE, `TI_SC_LSHIFT, `TI_SC_LCTRL, `TI_SC_LALT, `TI_SC_BTICK};
	localparam logic [8:0][7:0] COMBO_KEYS = {`TI_SC_QUOTE, `TI_SC_BKSP, `TI_SC_DEL,
		`TI_SC_INS, `TI_SC_ESC, `TI_SC_UP, `TI_SC_DOWN, `TI_SC_LEFT, `TI_SC_RIGHT};

	logic        clk_sys;
	logic        RESET;
	ioctl_t      ioctl;
	mem_wr_t     mem;
	cart_info_t  cart;
	ps2_key_t    ps2_key;
	logic        virt_joy;
	key_sel_t    key_sel;
	logic [7:0]  keys;
	logic [31:0] rng = 32'h8a5684bf;

	ti99_io_top i_dut (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.ioctl_i    (ioctl),
		.mem_o      (mem),
		.cart_o     (cart),
		.ps2_key_i  (ps2_key),
		.virt_joy_i (virt_joy),
		.key_sel_i  (key_sel),
		.keys_o     (keys)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;   // 50 MHz
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	// ========================================================================
	// Failure reporting and compare tasks
	// ========================================================================
	task automatic fail_run(input string msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_mem(input mem_wr_t exp, input mem_wr_t act);
		// Address and data only matter with the strobe up
		if ((act.wr !== exp.wr) ||
			(exp.wr && ((act.addr !== exp.addr) || (act.data !== exp.data)))) begin
			$display("[ERROR] %0t ns mem_o expected %h got %h", $time, exp, act);
			fail_run("memory write differs from the reference");
		end
	endtask

	task automatic check_cart(input cart_info_t exp, input cart_info_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t ns cart_o expected %h got %h", $time, exp, act);
			fail_run("cartridge description differs from the reference");
		end
	endtask

	task automatic check_keys(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t ns keys_o expected %h got %h", $time, exp, act);
			fail_run("key rows differ from the reference");
		end
	endtask

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic write_byte(input load_idx_e idx, input logic [26:0] addr,
			input logic [7:0] data);
		@(posedge clk_sys);
		ioctl <= '{download: 1'b1, wr: 1'b1, index: idx, addr: addr, data: data};
	endtask

	task automatic end_load();
		@(posedge clk_sys);
		ioctl.wr       <= 1'b0;
		ioctl.download <= 1'b0;
	endtask

	task automatic map_test();
		logic [26:0] a;
		for (int i = int'(IDX_ROM); i <= int'(IDX_PCODE); i++) begin
			for (int n = 0; n < N_MAP; n++) begin
				rng = xorshift32(rng);
				a   = rng[31] ? 27'(rng[19:0]) : 27'(rng[11:0]);   // Past or inside limit
				write_byte(load_idx_e'(i), a, rng[27:20]);
			end
		end
		end_load();
	endtask

	task automatic send_header(input load_idx_e idx, input logic [23:0] sig,
			input logic [2:0] typ, input logic [15:0] rb, input logic [15:0] gb);
		logic [7:0] b;
		for (int a = 0; a < `TI_M99_HDR_LEN; a++) begin
			rng = xorshift32(rng);
			case (a)
				0: b = sig[23:16];
				1: b = sig[15:8];
				2: b = sig[7:0];
				4: b = {rng[7:3], typ};
				5: b = rb[15:8];
				6: b = rb[7:0];
				7: b = gb[15:8];
				8: b = gb[7:0];
				default: b = rng[7:0];   // Version, title, filler
			endcase
			write_byte(idx, 27'(a), b);
		end
	endtask

	// Offsets around the 512K relocation point and around the GROM window
	task automatic send_payload(input load_idx_e idx);
		logic [26:0] off;
		for (int n = 0; n < N_PAY; n++) begin
			rng = xorshift32(rng);
			off = rng[0] ? 27'('h7C000 + rng[15:1]) : 27'('h84000 + rng[14:1]);
			write_byte(idx, off + `TI_M99_HDR_LEN, rng[31:24]);
		end
	endtask

	task automatic key_event(input logic [7:0] code, input logic down);
		@(posedge clk_sys);
		ps2_key <= '{toggle: ~ps2_key.toggle, pressed: down, extended: 1'b0, code: code};
	endtask

	// One column low per cycle, then the alpha line alone
	task automatic scan_columns();
		for (int c = 0; c < 9; c++) begin
			@(posedge clk_sys);
			key_sel <= key_sel_t'(9'h1FF ^ (9'h1 << c));
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		RESET    = 1'b1;
		ioctl    = '0;
		ps2_key  = '0;
		virt_joy = 1'b0;
		key_sel  = '1;
		repeat (5) @(posedge clk_sys);
		RESET <= 1'b0;

		map_test();

		// Good header, 65 ROM banks cross the relocation point
		send_header(IDX_BOOT, `TI_M99_SIG, 3'd5, 16'h0041, 16'h0002);
		end_load();
		@(negedge clk_sys);
		check_cart('{valid: 1'b1, cart_type: 3'd5, rom_banks: 16'h0041,
			grom_banks: 16'h0002}, cart);
		send_payload(IDX_BOOT);
		send_header(IDX_M99, 24'h4D3938, 3'd2, 16'h0010, 16'h0010);   // Bad signature
		send_payload(IDX_M99);
		end_load();
		@(negedge clk_sys);
		check_cart('{valid: 1'b0, cart_type: 3'd5, rom_banks: 16'h0041,
			grom_banks: 16'h0002}, cart);

		for (int n = 0; n < N_KEYS; n++) begin
			rng = xorshift32(rng);
			key_event(PLAIN_KEYS[rng[4:0] % 18], 1'b1);
			@(posedge clk_sys);
			key_sel <= {1'b1, rng[15:8]};
			@(posedge clk_sys);
			key_event(PLAIN_KEYS[rng[4:0] % 18], 1'b0);
			@(posedge clk_sys);
			key_sel <= key_sel_t'(rng[24:16]);
		end

		for (int v = 0; v < 2; v++) begin
			@(posedge clk_sys);
			virt_joy <= v[0];   // Arrows as FCTN keys, then as joystick
			for (int i = 0; i < 9; i++) begin
				key_event(COMBO_KEYS[i], 1'b1);
				scan_columns();
				key_event(COMBO_KEYS[i], 1'b0);
				scan_columns();
			end
		end

		for (int n = 0; n < 4; n++) begin
			key_event(`TI_SC_CAPS, 1'b1);
			scan_columns();
			key_event(`TI_SC_CAPS, 1'b0);   // Release must not flip the lock
			scan_columns();
		end

		repeat (4) @(posedge clk_sys);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// ========================================================================
	// Compare process, cycle model fed by last cycle's inputs
	// ========================================================================
	initial begin : compare
		ioctl_t      io_p;
		ps2_key_t    key_p;
		key_sel_t    sel_p;
		logic        vj_p;
		cart_info_t  cart_m;
		key_mat_t    mat_m;
		logic        alpha_m;
		logic        tog_m;
		logic [23:0] sig_m;
		logic [63:0] km;
		wait (RESET === 1'b0);
		@(negedge clk_sys);
		cart_m  = '0;
		mat_m   = '0;
		alpha_m = 1'b0;
		sig_m   = '0;
		tog_m   = ps2_key.toggle;
		io_p    = ioctl;
		key_p   = ps2_key;
		sel_p   = key_sel;
		vj_p    = virt_joy;
		check_keys(8'hFF, keys);   // Reset state
		check_cart('0, cart);
		check_mem('0, mem);
		forever begin
			@(negedge clk_sys);
			check_keys(ref_rows(mat_m, alpha_m, sel_p), keys);
			check_mem(ref_mem(io_p, cart_m), mem);   // Uses last cycle's cart
			sig_m  = ref_sig_next(sig_m, io_p);
			cart_m = ref_cart_next(cart_m, sig_m, io_p);
			check_cart(cart_m, cart);
			if (key_p.toggle != tog_m) begin
				if (key_p.code == `TI_SC_CAPS) begin
					alpha_m = alpha_m ^ key_p.pressed;
				end else begin
					km    = ref_key_mask(key_p.code, vj_p);
					mat_m = key_p.pressed ? key_mat_t'(mat_m | km) : key_mat_t'(mat_m & ~km);
				end
			end
			tog_m = key_p.toggle;
			io_p  = ioctl;
			key_p = ps2_key;
			sel_p = key_sel;
			vj_p  = virt_joy;
		end
	end

	// Watchdog
	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > MAX_CYCLES) begin
				fail_run($sformatf("timeout: run still busy after %0d cycles", cycles));
			end
		end
	end

endmodule

/* sim.f */
+incdir+common
+incdir+verif
common/ti99_pkg.sv
loader/m99_header.sv
loader/cart_loader.sv
keyboard/ps2_key_decode.sv
keyboard/key_matrix_scan.sv
rtl/ti99_io_top.sv
verif/tb_ti99_io.sv

/* Bender.yml */
package:
  name: ti99_io

sources:
  - include_dirs:
      - common
    files:
      - common/ti99_pkg.sv
      - loader/m99_header.sv
      - loader/cart_loader.sv
      - keyboard/ps2_key_decode.sv
      - keyboard/key_matrix_scan.sv
      - rtl/ti99_io_top.sv
  - target: test
    include_dirs:
      - common
      - verif
    files:
      - verif/tb_ti99_io.sv
